/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_fc_engine
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = Verification failed
PASS_MSG  = Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
logic/num_fmt_pkg.sv
logic/fc_layer_pkg.sv
logic/fc_sequencer.sv
logic/mac_unit.sv
logic/result_packer.sv
logic/fc_engine.sv
tb/fc_properties.sv
tb/fc_checker.sv
tb/tb_fc_engine.sv

/* logic/fc_engine.sv */
// Top of the FC layer engine; input word stream in, packed result stream out, done per job
module fc_engine (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    output logic               in_ready,
    input  num_fmt_pkg::word_t in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output num_fmt_pkg::word_t out_data,
    output logic               done
);

    import num_fmt_pkg::*;
    import fc_layer_pkg::*;

    logic      load_bias;
    logic      load_weight;
    unit_idx_t unit_sel;
    word_t     act_word;
    logic      mac_en;
    logic      quant_en;
    logic      wb_start;
    logic      wb_done;
    lane_t     results [NUM_UNITS];

    fc_sequencer i_fc_sequencer (
        .clk         (clk),
        .rstn        (rstn),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .load_bias   (load_bias),
        .load_weight (load_weight),
        .unit_sel    (unit_sel),
        .act_word    (act_word),
        .mac_en      (mac_en),
        .quant_en    (quant_en),
        .wb_start    (wb_start),
        .wb_done     (wb_done),
        .done        (done)
    );

    ////////////////////////////////////////////////////////////
    // Unit array
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_UNITS; g++) begin : g_unit
        mac_unit i_mac_unit (
            .clk         (clk),
            .rstn        (rstn),
            .load_bias   (load_bias),
            .load_weight (load_weight),
            .sel         (unit_sel == unit_idx_t'(g)),
            .in_data     (in_data),
            .act_word    (act_word),
            .mac_en      (mac_en),
            .quant_en    (quant_en),
            .result      (results[g])
        );
    end

    result_packer i_result_packer (
        .clk       (clk),
        .rstn      (rstn),
        .results   (results),
        .wb_start  (wb_start),
        .wb_done   (wb_done),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

endmodule

/* logic/fc_layer_pkg.sv */
// Layer sizes and sequencer states of the FC engine; import where the unit array is sized
package fc_layer_pkg;

    ////////////////////////////////////////////////////////////
    // Layer tile
    ////////////////////////////////////////////////////////////

    // Units working in parallel
    localparam int NUM_UNITS = 8;

    // Weight and input rounds per job
    localparam int NUM_STEPS = 2;

    // Arithmetic right shift before saturation to 8 bits
    localparam int OUT_SHIFT = 6;

    // Results packed into each output word
    localparam int RESULTS_PER_WORD = 4;
    localparam int NUM_OUT_WORDS = NUM_UNITS / RESULTS_PER_WORD;

    typedef logic [2:0] unit_idx_t;

    typedef logic [0:0] step_idx_t;

    ////////////////////////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        BIAS,
        WEIGHT,
        INPUT,
        RUN,
        QUANT,
        WBACK,
        FINISH
    } seq_state_t;

endpackage

/* logic/fc_sequencer.sv */
// Job FSM of the FC engine; reads the input stream and drives unit loads, MAC, quantize and write-back
module fc_sequencer (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  num_fmt_pkg::word_t    in_data,
    output logic                  load_bias,
    output logic                  load_weight,
    output fc_layer_pkg::unit_idx_t unit_sel,
    output num_fmt_pkg::word_t    act_word,
    output logic                  mac_en,
    output logic                  quant_en,
    output logic                  wb_start,
    input  logic                  wb_done,
    output logic                  done
);

    import fc_layer_pkg::*;

    seq_state_t state;
    unit_idx_t  unit_cnt;
    step_idx_t  step_cnt;
    logic       xfer;
    logic       last_unit;
    logic       last_step;

    // Stream is open only while words are expected
    assign in_ready = (state == BIAS) || (state == WEIGHT) || (state == INPUT);
    assign xfer     = in_valid && in_ready;

    assign last_unit = (unit_cnt == unit_idx_t'(NUM_UNITS - 1));
    assign last_step = (step_cnt == step_idx_t'(NUM_STEPS - 1));

    // Strobes to the counted unit
    assign load_bias   = xfer && (state == BIAS);
    assign load_weight = xfer && (state == WEIGHT);
    assign unit_sel    = unit_cnt;

    assign mac_en   = (state == RUN);
    assign quant_en = (state == QUANT);
    assign done     = (state == FINISH);

    ////////////////////////////////////////////////////////////
    // State and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= BIAS;
            unit_cnt <= '0;
            step_cnt <= '0;
            wb_start <= 1'b0;
        end else begin
            // Single pulse on entry to write-back
            wb_start <= (state == QUANT);
            case (state)
                BIAS: begin
                    if (xfer) begin
                        unit_cnt <= last_unit ? '0 : unit_cnt + 1'b1;
                        if (last_unit) begin
                            state <= WEIGHT;
                        end
                    end
                end
                WEIGHT: begin
                    if (xfer) begin
                        unit_cnt <= last_unit ? '0 : unit_cnt + 1'b1;
                        if (last_unit) begin
                            state <= INPUT;
                        end
                    end
                end
                INPUT: begin
                    if (xfer) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (last_step) begin
                        step_cnt <= '0;
                        state    <= QUANT;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                        state    <= WEIGHT;
                    end
                end
                QUANT: begin
                    state <= WBACK;
                end
                WBACK: begin
                    if (wb_done) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= BIAS;
                end
                default: begin
                    state <= BIAS;
                end
            endcase
        end
    end

    // Activation lanes of the current round
    always_ff @(posedge clk) begin
        if (xfer && (state == INPUT)) begin
            act_word <= in_data;
        end
    end

endmodule

/* logic/mac_unit.sv */
// One neuron of the FC array; holds weights and accumulator, instantiated once per unit by the top
module mac_unit (
    input  logic               clk,
    input  logic               rstn,
    input  logic               load_bias,
    input  logic               load_weight,
    input  logic               sel,
    input  num_fmt_pkg::word_t in_data,
    input  num_fmt_pkg::word_t act_word,
    input  logic               mac_en,
    input  logic               quant_en,
    output num_fmt_pkg::lane_t result
);

    import num_fmt_pkg::*;
    import fc_layer_pkg::*;

    lane_t weight [NUM_LANES];
    acc_t  acc;
    acc_t  mac_sum;
    acc_t  shifted;
    lane_t q_val;

    // Sum of the three lane products
    always_comb begin
        mac_sum = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            mac_sum += acc_t'(weight[l]) * acc_t'(lane_t'(act_word[l*LANE_W +: LANE_W]));
        end
    end

    // Shift, then clamp to the signed byte range
    always_comb begin
        shifted = acc >>> OUT_SHIFT;
        if (shifted > acc_t'(127)) begin
            q_val = lane_t'(127);
        end else if (shifted < acc_t'(-128)) begin
            q_val = lane_t'(-128);
        end else begin
            q_val = shifted[LANE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (load_weight && sel) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                weight[l] <= lane_t'(in_data[l*LANE_W +: LANE_W]);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc    <= '0;
            result <= '0;
        end else begin
            // Bias restarts the sum for each job
            if (load_bias && sel) begin
                acc <= acc_t'(in_data);
            end else if (mac_en) begin
                acc <= acc + mac_sum;
            end
            if (quant_en) begin
                result <= q_val;
            end
        end
    end

endmodule

/* logic/num_fmt_pkg.sv */
// Number formats shared by the FC engine; import where lane, word or accumulator types are needed
package num_fmt_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // One signed weight or activation
    localparam int LANE_W = 8;

    // Lanes packed into the low bits of a stream word
    localparam int NUM_LANES = 3;

    localparam int WORD_W = 32;

    // Accumulator and bias share one width
    localparam int ACC_W = 32;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic signed [LANE_W-1:0] lane_t;

    typedef logic [WORD_W-1:0] word_t;

    typedef logic signed [ACC_W-1:0] acc_t;

endpackage

/* logic/result_packer.sv */
// Write-back stage of the FC engine; packs unit results four per word onto the output stream
module result_packer (
    input  logic               clk,
    input  logic               rstn,
    input  num_fmt_pkg::lane_t results [fc_layer_pkg::NUM_UNITS],
    input  logic               wb_start,
    output logic               wb_done,
    output logic               out_valid,
    input  logic               out_ready,
    output num_fmt_pkg::word_t out_data
);

    import num_fmt_pkg::*;
    import fc_layer_pkg::*;

    localparam int IDX_W = (NUM_OUT_WORDS > 1) ? $clog2(NUM_OUT_WORDS) : 1;

    lane_t            res_q [NUM_UNITS];
    logic [IDX_W-1:0] word_idx;
    logic             out_xfer;
    logic             last_word;

    assign out_xfer  = out_valid && out_ready;
    assign last_word = (word_idx == IDX_W'(NUM_OUT_WORDS - 1));

    // Lowest unit of the group in the lowest byte
    always_comb begin
        for (int r = 0; r < RESULTS_PER_WORD; r++) begin
            out_data[r*LANE_W +: LANE_W] = res_q[int'(word_idx) * RESULTS_PER_WORD + r];
        end
    end

    // Snapshot of the array at write-back start
    always_ff @(posedge clk) begin
        if (wb_start) begin
            res_q <= results;
        end
    end

    ////////////////////////////////////////////////////////////
    // Word sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            word_idx  <= '0;
            wb_done   <= 1'b0;
        end else begin
            wb_done <= 1'b0;
            if (wb_start) begin
                out_valid <= 1'b1;
                word_idx  <= '0;
            end else if (out_xfer) begin
                if (last_word) begin
                    out_valid <= 1'b0;
                    wb_done   <= 1'b1;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
        end
    end

endmodule

/* tb/fc_checker.sv */
// Result checker of the FC engine testbench; compares output words and job framing with the trace
module fc_checker (
    input  logic               clk,
    input  logic               rstn,
    input  logic               in_valid,
    input  logic               in_ready,
    input  logic               out_valid,
    input  logic               out_ready,
    input  num_fmt_pkg::word_t out_data,
    input  logic               done,
    input  num_fmt_pkg::word_t exp_words [64],
    input  int                 exp_count,
    output int                 data_errors,
    output int                 proto_errors,
    output int                 jobs_done
);

    import fc_layer_pkg::*;

    int   out_idx;
    int   job_words;
    logic seen_input;
    logic in_wb;

    always @(posedge clk) begin
        if (!rstn) begin
            out_idx      = 0;
            job_words    = 0;
            seen_input   = 1'b0;
            in_wb        = 1'b0;
            data_errors  = 0;
            proto_errors = 0;
            jobs_done    = 0;
        end else begin
            // Idle after reset
            if (!seen_input && (!in_ready || out_valid || done)) begin
                $display("Protocol error at %0t: engine not idle after reset", $time);
                proto_errors++;
            end
            if (in_valid && in_ready) begin
                seen_input = 1'b1;
                if (in_wb) begin
                    $display("Protocol error at %0t: input word accepted during write-back",
                             $time);
                    proto_errors++;
                end
            end
            if (out_valid) begin
                in_wb = 1'b1;
            end

            ////////////////////////////////////////////////////////////
            // Output words
            ////////////////////////////////////////////////////////////

            if (out_valid && out_ready) begin
                if (out_idx >= exp_count) begin
                    $display("Protocol error at %0t: output word beyond the end of the trace",
                             $time);
                    proto_errors++;
                end else if (out_data !== exp_words[out_idx]) begin
                    $display("FAILED at %0t: out_data expected %h actual %h",
                             $time, exp_words[out_idx], out_data);
                    data_errors++;
                end
                out_idx++;
                job_words++;
            end
            if (done) begin
                if (job_words != NUM_OUT_WORDS) begin
                    $display("Protocol error at %0t: job ended after %0d output words, not %0d",
                             $time, job_words, NUM_OUT_WORDS);
                    proto_errors++;
                end
                job_words = 0;
                in_wb     = 1'b0;
                jobs_done++;
            end
        end
    end

endmodule

/* tb/fc_properties.sv */
// Handshake assertions for the FC engine; bound to fc_engine by the testbench top
module fc_properties (
    input logic               clk,
    input logic               rstn,
    input logic               in_valid,
    input logic               in_ready,
    input logic               out_valid,
    input logic               out_ready,
    input num_fmt_pkg::word_t out_data,
    input logic               done
);

    import fc_layer_pkg::*;

    localparam int JOB_WORDS = NUM_UNITS + NUM_STEPS * (NUM_UNITS + 1);

    int   in_cnt;
    logic busy;
    int   fail_count = 0;

    // Span from the last input word of a job up to its done pulse
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_cnt <= 0;
            busy   <= 1'b0;
        end else begin
            if (in_valid && in_ready) begin
                if (in_cnt == JOB_WORDS - 1) begin
                    in_cnt <= 0;
                    busy   <= 1'b1;
                end else begin
                    in_cnt <= in_cnt + 1;
                end
            end
            if (done) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stream rules
    ////////////////////////////////////////////////////////////

    hold_on_stall: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
        fail_count++;
        $error("Output word dropped or changed while stalled");
    end

    streams_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(in_ready && out_valid))
    else begin
        fail_count++;
        $error("Input ready and output valid high together");
    end

    closed_until_done: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> !in_ready)
    else begin
        fail_count++;
        $error("Input ready between last input word and done");
    end

    done_single: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
    else begin
        fail_count++;
        $error("Done pulse longer than one cycle");
    end

endmodule

/* tb/fc_trace.txt */
# Column 1: I = input word to the engine, O = expected output word
# Column 2: the word in hex; per job 8 biases, then 2 rounds of 8 weights and 1 input word
# Job 1: arithmetic shift of small negatives, saturation from bias, ignored top byte
I 00000040
I 00000040
I FFFFFFC0
I FFFFFFFF
I 00002710
I FFFFD8F0
I 00000064
I 00000000
I AA000000
I 000A0A0A
I 00000000
I 00000000
I 007F7F7F
I 00000000
I 00FFFFFF
I 00C00000
I 00030201
I 00000000
I 00000001
I 00000000
I 00000000
I 0080007F
I 00000000
I 00030502
I 00000000
I 00FF0004
O FFFF0201
O FD01807F
# Job 2: saturation from products, exact range limits
I 00000000
I 00000000
I 00000000
I 00000000
I 00000020
I FFFFFFE0
I 00001F41
I 00000000
I 0000007F
I 00007F00
I 00000000
I 00000000
I 00400000
I 00000000
I 00000101
I 00000040
I 00017F80
I 00800000
I 00000000
I 00010000
I 00FF0000
I 00001010
I 00000000
I 00020000
I 00000000
I 0040FE02
O FF017F80
O 807FFF01
# Job 3: extreme biases, accumulators restart from bias
I 7FFFFFFF
I 80000000
I 00000000
I 00000000
I 00000000
I 00000000
I 000003E8
I 00000000
I 00000000
I 00000000
I 0000000A
I 00000A00
I 00640000
I 0000009C
I 00000000
I 00000000
I 0007FB03
I 00000000
I 00000000
I 000003FE
I 00000000
I 00000000
I 00009C00
I 00000014
I 00000000
I 00000BF9
O FF01807F
O 000DEA0A

/* tb/tb_fc_engine.sv */
// Testbench top for the FC engine; replays tb/fc_trace.txt through the DUT with random stalls
module tb_fc_engine;

    import num_fmt_pkg::*;
    import fc_layer_pkg::*;

    localparam int MAX_EXP = 64;

    logic  clk = 1'b0;
    logic  rstn = 1'b0;
    logic  in_valid = 1'b0;
    logic  in_ready;
    word_t in_data = '0;
    logic  out_valid;
    logic  out_ready = 1'b0;
    word_t out_data;
    logic  done;

    word_t in_words [$];
    word_t exp_words [MAX_EXP];
    int    exp_count = 0;
    int    num_lines = 0;
    int    in_idx = 0;
    int    seed = 32'h95d546e3;
    logic  in_xfer_q = 1'b0;
    logic  rstn_q = 1'b0;
    logic  run_error = 1'b0;
    int    data_errors;
    int    proto_errors;
    int    jobs_done;

    fc_engine i_fc_engine (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .done      (done)
    );

    fc_checker i_fc_checker (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .done         (done),
        .exp_words    (exp_words),
        .exp_count    (exp_count),
        .data_errors  (data_errors),
        .proto_errors (proto_errors),
        .jobs_done    (jobs_done)
    );

    bind fc_engine fc_properties i_fc_properties (.*);

    always #5 clk = ~clk;

    task automatic read_trace();
        int    fd;
        int    n;
        string line;
        byte   kind;
        word_t value;
        fd = $fopen("tb/fc_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file tb/fc_trace.txt");
            run_error = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %h", kind, value);
            if (n == 2 && kind == "I") begin
                in_words.push_back(value);
                num_lines++;
            end else if (n == 2 && kind == "O" && exp_count < MAX_EXP) begin
                exp_words[exp_count] = value;
                exp_count++;
                num_lines++;
            end
        end
        $fclose(fd);
        if (exp_count == 0 || exp_count % NUM_OUT_WORDS != 0) begin
            $display("The trace holds no whole jobs of expected output words");
            run_error = 1'b1;
        end
    endtask

    task automatic report_and_finish();
        int assert_errors;
        int total;
        assert_errors = i_fc_engine.i_fc_properties.fail_count;
        total = data_errors + proto_errors + assert_errors + int'(run_error);
        $display("Errors: %0d data, %0d protocol, %0d assertion, %0d run",
                 data_errors, proto_errors, assert_errors, int'(run_error));
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Transfer and reset seen at the rising edge, used at the next falling edge
    always @(posedge clk) begin
        in_xfer_q <= in_valid && in_ready;
        rstn_q    <= rstn;
    end

    always @(negedge clk) begin
        if (rstn_q) begin
            if (in_xfer_q) begin
                in_idx++;
            end
            // An offered word stays until it transfers
            if (in_xfer_q || !in_valid) begin
                if (in_idx < in_words.size() && ($random(seed) % 4) != 0) begin
                    in_valid <= 1'b1;
                    in_data  <= in_words[in_idx];
                end else begin
                    in_valid <= 1'b0;
                end
            end
            out_ready <= ($random(seed) % 3) != 0;
        end
    end

    initial begin
        read_trace();
        if (!run_error) begin
            repeat (5) @(posedge clk);
            @(negedge clk);
            rstn = 1'b1;
            wait (jobs_done == exp_count / NUM_OUT_WORDS);
            repeat (4) @(posedge clk);
        end
        report_and_finish();
    end

    // Watchdog
    initial begin
        #1;
        repeat (40 * num_lines + 100) @(posedge clk);
        $display("Timeout: the jobs of the trace did not finish in time");
        run_error = 1'b1;
        report_and_finish();
    end

endmodule
